// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_ex_stage
OBJ_DIR   ?= obj_dir
FILELIST  ?= sim.f
VFLAGS    ?= --binary --timing --timescale 1ns/1ns -j 0
PASS_MSG  ?= Test completed successfully

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST))
HEADERS := $(wildcard test/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@out="$$($(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: design/ex_alu.sv
`timescale 1ns/1ns

module ex_alu import ex_pkg::*; (
  input  alu_op_e           operator_i,
  input  logic [DATA_W-1:0] operand_a_i,
  input  logic [DATA_W-1:0] operand_b_i,
  output logic [DATA_W-1:0] result_o,
  output logic              cmp_result_o
);

  // Adder path
  logic                sub_en;
  logic [DATA_W-1:0]   adder_b;
  logic [DATA_W:0]     adder_sum;

  // Comparison flags
  logic                is_equal;
  logic                lt_unsigned;
  logic                lt_signed;

  // Shifter path
  logic [SHAMT_W-1:0]  shamt;
  logic                shift_left;
  logic                shift_arith;
  logic [DATA_W-1:0]   a_reversed;
  logic [DATA_W-1:0]   shift_in;
  logic [DATA_W:0]     shift_ext;
  logic [DATA_W:0]     shift_out;
  logic [DATA_W-1:0]   shift_right;
  logic [DATA_W-1:0]   shift_right_rev;

  //////////////////////////////////////////////////////////////////////
  // Adder and comparisons
  //////////////////////////////////////////////////////////////////////

  // Everything that compares goes through the subtractor
  always_comb begin
    case (operator_i)
      ALU_SUB, ALU_SLT, ALU_SLTU,
      ALU_LT, ALU_GE, ALU_LTU, ALU_GEU: sub_en = 1'b1;
      default:                          sub_en = 1'b0;
    endcase
  end

  // Two's complement subtract as A + ~B + 1
  assign adder_b   = sub_en ? ~operand_b_i : operand_b_i;
  assign adder_sum = {1'b0, operand_a_i} + {1'b0, adder_b} + {{DATA_W{1'b0}}, sub_en};

  assign is_equal    = (operand_a_i == operand_b_i);
  // No carry out of A - B means A is below B
  assign lt_unsigned = ~adder_sum[DATA_W];
  // Differing signs decide directly, else the difference sign does
  assign lt_signed   = (operand_a_i[DATA_W-1] != operand_b_i[DATA_W-1]) ?
                       operand_a_i[DATA_W-1] : adder_sum[DATA_W-1];

  // Branch compares and set-less-than share one flag
  always_comb begin
    case (operator_i)
      ALU_EQ:            cmp_result_o = is_equal;
      ALU_NE:            cmp_result_o = ~is_equal;
      ALU_LT, ALU_SLT:   cmp_result_o = lt_signed;
      ALU_GE:            cmp_result_o = ~lt_signed;
      ALU_LTU, ALU_SLTU: cmp_result_o = lt_unsigned;
      ALU_GEU:           cmp_result_o = ~lt_unsigned;
      default:           cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Shifter
  //////////////////////////////////////////////////////////////////////

  // Only the low bits of B count
  assign shamt       = operand_b_i[SHAMT_W-1:0];
  assign shift_left  = (operator_i == ALU_SLL);
  assign shift_arith = (operator_i == ALU_SRA);

  // Left shifts run through the right shifter on a bit-reversed word
  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      a_reversed[i] = operand_a_i[DATA_W-1-i];
    end
  end

  assign shift_in  = shift_left ? a_reversed : operand_a_i;
  // Extra top bit carries the fill value for SRA
  assign shift_ext = {shift_arith & operand_a_i[DATA_W-1], shift_in};
  assign shift_out = $signed(shift_ext) >>> shamt;

  assign shift_right = shift_out[DATA_W-1:0];

  // Undo the reversal for SLL
  always_comb begin
    for (int i = 0; i < DATA_W; i++) begin
      shift_right_rev[i] = shift_right[DATA_W-1-i];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (operator_i)
      ALU_ADD, ALU_SUB: result_o = adder_sum[DATA_W-1:0];
      ALU_AND:          result_o = operand_a_i & operand_b_i;
      ALU_OR:           result_o = operand_a_i | operand_b_i;
      ALU_XOR:          result_o = operand_a_i ^ operand_b_i;
      ALU_SLL:          result_o = shift_right_rev;
      ALU_SRL, ALU_SRA: result_o = shift_right;
      // SLT, SLTU and the branch compares return the flag zero extended
      default:          result_o = {{(DATA_W-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

// File: design/ex_mult.sv
`timescale 1ns/1ns

module ex_mult import ex_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              enable_i,
  input  mult_op_e          operator_i,
  input  logic [DATA_W-1:0] op_a_i,
  input  logic [DATA_W-1:0] op_b_i,
  input  logic              ex_ready_i,
  output logic [DATA_W-1:0] result_o,
  output logic              ready_o,
  output logic              multicycle_o
);

  // Sequencer
  mult_state_e state_q;
  mult_state_e state_d;
  logic        high_op;
  logic        acc_load;
  logic        acc_add;

  // Operand signedness per operator
  logic        sign_a;
  logic        sign_b;

  // Extended operands and the two partial products
  logic signed [DATA_W:0]     a_ext;
  logic signed [DATA_W:0]     b_ext;
  logic signed [DATA_W/2:0]   b_lo;
  logic signed [DATA_W/2:0]   b_hi;
  logic signed [2*DATA_W-1:0] pp_lo;
  logic signed [2*DATA_W-1:0] pp_hi;

  // Full product accumulator and single-cycle low product
  logic [2*DATA_W-1:0] acc_q;
  logic [DATA_W-1:0]   prod_lo;

  //////////////////////////////////////////////////////////////////////
  // Operand preparation
  //////////////////////////////////////////////////////////////////////

  assign high_op = (operator_i != MUL_LO);

  always_comb begin
    case (operator_i)
      MUL_H:   {sign_a, sign_b} = 2'b11;
      MUL_HSU: {sign_a, sign_b} = 2'b10;
      default: {sign_a, sign_b} = 2'b00;
    endcase
  end

  // One extra bit turns every form into a signed 33x33 multiply
  assign a_ext = {sign_a & op_a_i[DATA_W-1], op_a_i};
  assign b_ext = {sign_b & op_b_i[DATA_W-1], op_b_i};

  // Low half of B is always positive, high half keeps the sign
  assign b_lo = {1'b0, op_b_i[DATA_W/2-1:0]};
  assign b_hi = b_ext[DATA_W:DATA_W/2];

  // Products are computed at 64 bits so they come out exact
  assign pp_lo = a_ext * b_lo;
  assign pp_hi = a_ext * b_hi;

  // Lower word does not depend on signedness
  assign prod_lo = op_a_i * op_b_i;

  //////////////////////////////////////////////////////////////////////
  // High product sequencer
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d  = state_q;
    ready_o  = 1'b1;
    acc_load = 1'b0;
    acc_add  = 1'b0;
    case (state_q)
      MS_IDLE: begin
        // MUL_LO finishes right here and never leaves idle
        if (enable_i && high_op) begin
          ready_o  = 1'b0;
          acc_load = 1'b1;
          state_d  = MS_STEP;
        end
      end
      MS_STEP: begin
        ready_o = 1'b0;
        acc_add = 1'b1;
        state_d = MS_FINISH;
      end
      MS_FINISH: begin
        // Result held here while the pipeline is stalled
        if (ex_ready_i) begin
          state_d = MS_IDLE;
        end
      end
      default: begin
        state_d = MS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // First the low partial product, then the high one shifted by half a word
  always_ff @(posedge clk) begin
    if (acc_load) begin
      acc_q <= pp_lo;
    end else if (acc_add) begin
      acc_q <= acc_q + (pp_hi <<< (DATA_W/2));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Outputs
  //////////////////////////////////////////////////////////////////////

  assign result_o     = (state_q == MS_FINISH) ? acc_q[2*DATA_W-1:DATA_W] : prod_lo;
  assign multicycle_o = (state_q == MS_STEP) || (state_q == MS_FINISH);

endmodule

// File: design/ex_pkg.sv
package ex_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////

  // Integer datapath word
  localparam int unsigned DATA_W     = 32;
  // Register file index including the upper bank bit
  localparam int unsigned REG_ADDR_W = 6;
  // Shift amount taken from operand B
  localparam int unsigned SHAMT_W    = 5;

  //////////////////////////////////////////////////////////////////////
  // Operator encodings
  //////////////////////////////////////////////////////////////////////

  // ALU operators, arithmetic first and branch compares last
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLL  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_SLT  = 4'd8,
    ALU_SLTU = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  // Multiplier operators, low product plus the three high forms
  typedef enum logic [1:0] {
    MUL_LO  = 2'd0,
    MUL_H   = 2'd1,
    MUL_HSU = 2'd2,
    MUL_HU  = 2'd3
  } mult_op_e;

  // Multiplier sequencer states
  typedef enum logic [1:0] {
    MS_IDLE   = 2'd0,
    MS_STEP   = 2'd1,
    MS_FINISH = 2'd2
  } mult_state_e;

endpackage

// File: design/ex_stage.sv
`timescale 1ns/1ns

module ex_stage import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // ALU inputs from ID
  input  alu_op_e               alu_operator_i,
  input  logic [DATA_W-1:0]     alu_operand_a_i,
  input  logic [DATA_W-1:0]     alu_operand_b_i,
  input  logic [DATA_W-1:0]     alu_operand_c_i,
  input  logic                  alu_en_i,

  // Multiplier inputs from ID
  input  mult_op_e              mult_operator_i,
  input  logic [DATA_W-1:0]     mult_operand_a_i,
  input  logic [DATA_W-1:0]     mult_operand_b_i,
  input  logic                  mult_en_i,
  output logic                  mult_multicycle_o,

  // Load/store unit
  input  logic                  lsu_en_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,
  input  logic                  lsu_ready_ex_i,
  input  logic                  lsu_err_i,

  input  logic                  branch_in_ex_i,

  // Destination registers
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_alu_we_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,

  // CSR access
  input  logic                  csr_access_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,

  // Write ports
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic                  regfile_we_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic                  regfile_alu_we_fw_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_fw_o,

  // Branch resolution towards IF
  output logic [DATA_W-1:0]     jump_target_o,
  output logic                  branch_decision_o,

  // Stall control
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,
  input  logic                  wb_ready_i
);

  logic [DATA_W-1:0] alu_result;
  logic              alu_cmp_result;
  logic [DATA_W-1:0] mult_result;
  logic              mult_ready;
  logic              any_en;

  //////////////////////////////////////////////////////////////////////
  // Execution units
  //////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operator_i   (alu_operator_i),
    .operand_a_i  (alu_operand_a_i),
    .operand_b_i  (alu_operand_b_i),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // ex_ready_o only releases the multiplier from its finish state
  ex_mult u_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable_i     (mult_en_i),
    .operator_i   (mult_operator_i),
    .op_a_i       (mult_operand_a_i),
    .op_b_i       (mult_operand_b_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mult_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  ex_writeback u_writeback (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_en_i               (alu_en_i),
    .mult_en_i              (mult_en_i),
    .csr_access_i           (csr_access_i),
    .alu_result_i           (alu_result),
    .mult_result_i          (mult_result),
    .csr_rdata_i            (csr_rdata_i),
    .lsu_rdata_i            (lsu_rdata_i),
    .regfile_alu_we_i       (regfile_alu_we_i),
    .regfile_alu_waddr_i    (regfile_alu_waddr_i),
    .regfile_we_i           (regfile_we_i),
    .regfile_waddr_i        (regfile_waddr_i),
    .lsu_err_i              (lsu_err_i),
    .ex_valid_i             (ex_valid_o),
    .wb_ready_i             (wb_ready_i),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw_o),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw_o),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw_o),
    .regfile_we_wb_o        (regfile_we_wb_o),
    .regfile_waddr_wb_o     (regfile_waddr_wb_o),
    .regfile_wdata_wb_o     (regfile_wdata_wb_o)
  );

  //////////////////////////////////////////////////////////////////////
  // Branch and handshake
  //////////////////////////////////////////////////////////////////////

  // Target comes precomputed from ID in operand C
  assign branch_decision_o = alu_cmp_result;
  assign jump_target_o     = alu_operand_c_i;

  assign any_en = alu_en_i | mult_en_i | csr_access_i | lsu_en_i;

  // Branches resolve in EX and need nothing downstream
  assign ex_ready_o = (mult_ready & lsu_ready_ex_i & wb_ready_i) | branch_in_ex_i;
  // Valid looks right only, so it does not depend on ex_ready_o
  assign ex_valid_o = any_en & mult_ready & lsu_ready_ex_i & wb_ready_i;

endmodule

// File: design/ex_writeback.sv
`timescale 1ns/1ns

module ex_writeback import ex_pkg::*; (
  input  logic                  clk,
  input  logic                  rst_n,

  // Result sources
  input  logic                  alu_en_i,
  input  logic                  mult_en_i,
  input  logic                  csr_access_i,
  input  logic [DATA_W-1:0]     alu_result_i,
  input  logic [DATA_W-1:0]     mult_result_i,
  input  logic [DATA_W-1:0]     csr_rdata_i,
  input  logic [DATA_W-1:0]     lsu_rdata_i,

  // Destination registers from ID
  input  logic                  regfile_alu_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_alu_waddr_i,
  input  logic                  regfile_we_i,
  input  logic [REG_ADDR_W-1:0] regfile_waddr_i,

  // Pipeline control
  input  logic                  lsu_err_i,
  input  logic                  ex_valid_i,
  input  logic                  wb_ready_i,

  // Forwarding port towards ID and the register file
  output logic                  regfile_alu_we_fw_o,
  output logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw_o,
  output logic [DATA_W-1:0]     regfile_alu_wdata_fw_o,

  // Load/store port after the EX/WB register
  output logic                  regfile_we_wb_o,
  output logic [REG_ADDR_W-1:0] regfile_waddr_wb_o,
  output logic [DATA_W-1:0]     regfile_wdata_wb_o
);

  logic                  lsu_we_q;
  logic [REG_ADDR_W-1:0] lsu_waddr_q;
  logic                  lsu_we_d;

  //////////////////////////////////////////////////////////////////////
  // Forwarding port
  //////////////////////////////////////////////////////////////////////

  assign regfile_alu_we_fw_o    = regfile_alu_we_i;
  assign regfile_alu_waddr_fw_o = regfile_alu_waddr_i;

  // CSR read data wins, then the multiplier, then the ALU
  always_comb begin
    if (csr_access_i) begin
      regfile_alu_wdata_fw_o = csr_rdata_i;
    end else if (mult_en_i) begin
      regfile_alu_wdata_fw_o = mult_result_i;
    end else if (alu_en_i) begin
      regfile_alu_wdata_fw_o = alu_result_i;
    end else begin
      regfile_alu_wdata_fw_o = '0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // EX/WB register for the load/store port
  //////////////////////////////////////////////////////////////////////

  // A faulting access never reaches the register file
  assign lsu_we_d = regfile_we_i & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q    <= 1'b0;
      lsu_waddr_q <= '0;
    end else if (ex_valid_i) begin
      lsu_we_q <= lsu_we_d;
      if (lsu_we_d) begin
        lsu_waddr_q <= regfile_waddr_i;
      end
    end else if (wb_ready_i) begin
      // WB took the old entry and nothing new arrived
      lsu_we_q <= 1'b0;
    end
  end

  assign regfile_we_wb_o    = lsu_we_q;
  assign regfile_waddr_wb_o = lsu_waddr_q;
  // Load data arrives from the LSU in the WB cycle itself
  assign regfile_wdata_wb_o = lsu_rdata_i;

endmodule

// File: sim.f
+incdir+test
design/ex_pkg.sv
design/ex_alu.sv
design/ex_mult.sv
design/ex_writeback.sv
design/ex_stage.sv
test/tb_ex_stage.sv

// File: test/ex_model.svh
`ifndef EX_MODEL_SVH
`define EX_MODEL_SVH

//////////////////////////////////////////////////////////////////////
// Reference model of the execute stage
//////////////////////////////////////////////////////////////////////

// Compare flag as the ISA defines it for branches and set-less-than
function automatic logic cmp_model(input alu_op_e op, input logic [DATA_W-1:0] a,
                                   input logic [DATA_W-1:0] b);
  case (op)
    ALU_EQ:            return a == b;
    ALU_NE:            return a != b;
    ALU_LT, ALU_SLT:   return $signed(a) < $signed(b);
    ALU_GE:            return $signed(a) >= $signed(b);
    ALU_LTU, ALU_SLTU: return a < b;
    ALU_GEU:           return a >= b;
    default:           return 1'b0;
  endcase
endfunction

// ALU result, compares give the flag zero extended
function automatic logic [DATA_W-1:0] alu_model(input alu_op_e op, input logic [DATA_W-1:0] a,
                                                input logic [DATA_W-1:0] b);
  logic signed [DATA_W-1:0] sa;
  logic [SHAMT_W-1:0]       sh;
  sa = a;
  sh = b[SHAMT_W-1:0];
  case (op)
    ALU_ADD: return a + b;
    ALU_SUB: return a - b;
    ALU_AND: return a & b;
    ALU_OR:  return a | b;
    ALU_XOR: return a ^ b;
    ALU_SLL: return a << sh;
    ALU_SRL: return a >> sh;
    ALU_SRA: return sa >>> sh;
    default: return {{(DATA_W-1){1'b0}}, cmp_model(op, a, b)};
  endcase
endfunction

// Multiply at 66 bits so every signedness mix is exact
function automatic logic [DATA_W-1:0] mult_model(input mult_op_e op, input logic [DATA_W-1:0] a,
                                                 input logic [DATA_W-1:0] b);
  logic signed [2*DATA_W+1:0] ea;
  logic signed [2*DATA_W+1:0] eb;
  logic signed [2*DATA_W+1:0] prod;
  logic                       a_signed;
  logic                       b_signed;
  a_signed = (op == MUL_H) || (op == MUL_HSU);
  b_signed = (op == MUL_H);
  ea   = {{(DATA_W+2){a_signed & a[DATA_W-1]}}, a};
  eb   = {{(DATA_W+2){b_signed & b[DATA_W-1]}}, b};
  prod = ea * eb;
  if (op == MUL_LO) begin
    return prod[DATA_W-1:0];
  end
  return prod[2*DATA_W-1:DATA_W];
endfunction

// Forwarding data, CSR first, then multiplier, then ALU
function automatic logic [DATA_W-1:0] fwd_model(input logic csr, input logic mul, input logic alu,
                                                input logic [DATA_W-1:0] csr_d,
                                                input logic [DATA_W-1:0] mul_d,
                                                input logic [DATA_W-1:0] alu_d);
  if (csr) begin
    return csr_d;
  end
  if (mul) begin
    return mul_d;
  end
  if (alu) begin
    return alu_d;
  end
  return '0;
endfunction

`endif

// File: test/tb_ex_stage.sv
`timescale 1ns/1ns

module tb_ex_stage import ex_pkg::*; ();

  // Operations per test
  localparam int N_ALU = 60;
  localparam int N_BR  = 40;
  localparam int N_MUL = 40;
  localparam int N_FWD = 40;
  localparam int N_WB  = 30;
  localparam int N_BP  = 60;
  localparam int N_RST = 8;
  // Four cycles per operation with a multiply counted as three operations
  localparam int CYCLE_LIMIT = 4 * (N_ALU + N_BR + 3 * N_MUL + N_FWD + N_WB + N_BP) + N_RST;

  logic                  clk;
  logic                  rst_n;
  alu_op_e               alu_operator;
  logic [DATA_W-1:0]     alu_operand_a;
  logic [DATA_W-1:0]     alu_operand_b;
  logic [DATA_W-1:0]     alu_operand_c;
  logic                  alu_en;
  mult_op_e              mult_operator;
  logic [DATA_W-1:0]     mult_operand_a;
  logic [DATA_W-1:0]     mult_operand_b;
  logic                  mult_en;
  logic                  mult_multicycle;
  logic                  lsu_en;
  logic [DATA_W-1:0]     lsu_rdata;
  logic                  lsu_ready_ex;
  logic                  lsu_err;
  logic                  branch_in_ex;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr;
  logic                  regfile_alu_we;
  logic                  regfile_we;
  logic [REG_ADDR_W-1:0] regfile_waddr;
  logic                  csr_access;
  logic [DATA_W-1:0]     csr_rdata;
  logic [REG_ADDR_W-1:0] regfile_waddr_wb;
  logic                  regfile_we_wb;
  logic [DATA_W-1:0]     regfile_wdata_wb;
  logic [REG_ADDR_W-1:0] regfile_alu_waddr_fw;
  logic                  regfile_alu_we_fw;
  logic [DATA_W-1:0]     regfile_alu_wdata_fw;
  logic [DATA_W-1:0]     jump_target;
  logic                  branch_decision;
  logic                  ex_ready;
  logic                  ex_valid;
  logic                  wb_ready;

  // Scoreboard state
  integer                seed;
  int                    errors;
  int                    cycle_count;
  int                    n_low;
  int                    sel;
  logic [DATA_W-1:0]     r;
  logic                  exp_we;
  logic [REG_ADDR_W-1:0] last_waddr;

  `include "ex_model.svh"

  ex_stage DUT (
    .clk                    (clk),
    .rst_n                  (rst_n),
    .alu_operator_i         (alu_operator),
    .alu_operand_a_i        (alu_operand_a),
    .alu_operand_b_i        (alu_operand_b),
    .alu_operand_c_i        (alu_operand_c),
    .alu_en_i               (alu_en),
    .mult_operator_i        (mult_operator),
    .mult_operand_a_i       (mult_operand_a),
    .mult_operand_b_i       (mult_operand_b),
    .mult_en_i              (mult_en),
    .mult_multicycle_o      (mult_multicycle),
    .lsu_en_i               (lsu_en),
    .lsu_rdata_i            (lsu_rdata),
    .lsu_ready_ex_i         (lsu_ready_ex),
    .lsu_err_i              (lsu_err),
    .branch_in_ex_i         (branch_in_ex),
    .regfile_alu_waddr_i    (regfile_alu_waddr),
    .regfile_alu_we_i       (regfile_alu_we),
    .regfile_we_i           (regfile_we),
    .regfile_waddr_i        (regfile_waddr),
    .csr_access_i           (csr_access),
    .csr_rdata_i            (csr_rdata),
    .regfile_waddr_wb_o     (regfile_waddr_wb),
    .regfile_we_wb_o        (regfile_we_wb),
    .regfile_wdata_wb_o     (regfile_wdata_wb),
    .regfile_alu_waddr_fw_o (regfile_alu_waddr_fw),
    .regfile_alu_we_fw_o    (regfile_alu_we_fw),
    .regfile_alu_wdata_fw_o (regfile_alu_wdata_fw),
    .jump_target_o          (jump_target),
    .branch_decision_o      (branch_decision),
    .ex_ready_o             (ex_ready),
    .ex_valid_o             (ex_valid),
    .wb_ready_i             (wb_ready)
  );

  //////////////////////////////////////////////////////////////////////
  // Clock and run limit
  //////////////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    cycle_count = 0;
    while (cycle_count < CYCLE_LIMIT) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles, errors so far: %0d",
             CYCLE_LIMIT, errors);
    $display("Test failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input string name, input logic [DATA_W-1:0] expected,
                       input logic [DATA_W-1:0] actual);
    if (expected !== actual) begin
      errors++;
      $display("CHECK FAILED %s: expected 0x%08h actual 0x%08h", name, expected, actual);
    end
  endtask

  // No unit enabled and everything downstream ready
  task automatic drive_idle();
    alu_en         = 1'b0;
    mult_en        = 1'b0;
    lsu_en         = 1'b0;
    csr_access     = 1'b0;
    branch_in_ex   = 1'b0;
    lsu_ready_ex   = 1'b1;
    wb_ready       = 1'b1;
    lsu_err        = 1'b0;
    regfile_we     = 1'b0;
    regfile_alu_we = 1'b0;
    mult_operator  = MUL_LO;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus driven on the falling edge and sampled 2 ns later
  //////////////////////////////////////////////////////////////////////

  initial begin
    seed              = 32'had0e_10e6;
    errors            = 0;
    last_waddr        = '0;
    rst_n             = 1'b0;
    alu_operator      = ALU_ADD;
    alu_operand_a     = '0;
    alu_operand_b     = '0;
    alu_operand_c     = '0;
    mult_operand_a    = '0;
    mult_operand_b    = '0;
    lsu_rdata         = '0;
    csr_rdata         = '0;
    regfile_alu_waddr = '0;
    regfile_waddr     = '0;
    drive_idle();
    repeat (N_RST) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // ALU results through the forwarding port
    for (int i = 0; i < N_ALU; i++) begin
      @(negedge clk);
      r                 = $random(seed);
      alu_operator      = alu_op_e'(r[3:0]);
      regfile_alu_we    = r[4];
      regfile_alu_waddr = r[10:5];
      alu_operand_a     = $random(seed);
      alu_operand_b     = $random(seed);
      alu_en            = 1'b1;
      #2;
      check($sformatf("alu %s", alu_operator.name()),
            alu_model(alu_operator, alu_operand_a, alu_operand_b), regfile_alu_wdata_fw);
      check("alu fw we", 32'(regfile_alu_we), 32'(regfile_alu_we_fw));
      check("alu fw waddr", 32'(regfile_alu_waddr), 32'(regfile_alu_waddr_fw));
    end

    // Branch compares with equal operands now and then
    for (int i = 0; i < N_BR; i++) begin
      @(negedge clk);
      r             = $random(seed);
      sel           = r[7:0] % 6;
      alu_operator  = alu_op_e'(4'(sel + 10));
      alu_operand_a = $random(seed);
      alu_operand_b = r[8] ? alu_operand_a : $random(seed);
      alu_operand_c = $random(seed);
      alu_en        = 1'b1;
      branch_in_ex  = 1'b1;
      #2;
      check($sformatf("branch %s", alu_operator.name()),
            32'(cmp_model(alu_operator, alu_operand_a, alu_operand_b)), 32'(branch_decision));
      check("jump target", alu_operand_c, jump_target);
    end

    // Multiplier where the high forms stall for two cycles
    @(negedge clk);
    drive_idle();
    for (int i = 0; i < N_MUL; i++) begin
      @(negedge clk);
      r              = $random(seed);
      mult_operator  = mult_op_e'(r[1:0]);
      mult_operand_a = r[2] ? 32'h8000_0000 : $random(seed);
      mult_operand_b = r[3] ? 32'hffff_ffff : $random(seed);
      mult_en        = 1'b1;
      #2;
      n_low = 0;
      // Count the cycles with ex_ready low
      while (ex_ready !== 1'b1) begin
        n_low++;
        @(negedge clk);
        #2;
      end
      check($sformatf("mult %s stall", mult_operator.name()),
            (mult_operator == MUL_LO) ? 32'd0 : 32'd2, 32'(n_low));
      check($sformatf("mult %s", mult_operator.name()),
            mult_model(mult_operator, mult_operand_a, mult_operand_b), regfile_alu_wdata_fw);
      check("mult multicycle", 32'(mult_operator != MUL_LO), 32'(mult_multicycle));
    end

    // Forwarding priority with the single-cycle multiply only
    for (int i = 0; i < N_FWD; i++) begin
      @(negedge clk);
      r              = $random(seed);
      csr_access     = r[0];
      mult_en        = r[1];
      alu_en         = r[2];
      mult_operator  = MUL_LO;
      alu_operator   = alu_op_e'(r[7:4]);
      alu_operand_a  = $random(seed);
      alu_operand_b  = $random(seed);
      mult_operand_a = $random(seed);
      mult_operand_b = $random(seed);
      csr_rdata      = $random(seed);
      #2;
      check($sformatf("fwd csr=%0b mul=%0b alu=%0b", csr_access, mult_en, alu_en),
            fwd_model(csr_access, mult_en, alu_en, csr_rdata,
                      mult_model(MUL_LO, mult_operand_a, mult_operand_b),
                      alu_model(alu_operator, alu_operand_a, alu_operand_b)),
            regfile_alu_wdata_fw);
    end

    // EX/WB register capture and then flush on an idle edge
    for (int i = 0; i < N_WB; i++) begin
      @(negedge clk);
      drive_idle();
      r             = $random(seed);
      lsu_en        = 1'b1;
      regfile_we    = r[0];
      lsu_err       = r[1] & r[2];
      regfile_waddr = r[8:3];
      exp_we        = regfile_we & ~lsu_err;
      if (exp_we) begin
        last_waddr = regfile_waddr;
      end
      #2;
      check("wb ex_valid", 32'd1, 32'(ex_valid));
      @(negedge clk);
      drive_idle();
      lsu_rdata = $random(seed);
      #2;
      check("wb we", 32'(exp_we), 32'(regfile_we_wb));
      check("wb waddr", 32'(last_waddr), 32'(regfile_waddr_wb));
      check("wb wdata", lsu_rdata, regfile_wdata_wb);
      @(negedge clk);
      #2;
      check("wb flush", 32'd0, 32'(regfile_we_wb));
      check("wb waddr held", 32'(last_waddr), 32'(regfile_waddr_wb));
    end

    // Back-pressure from LSU and WB while branches still release EX
    for (int i = 0; i < N_BP; i++) begin
      @(negedge clk);
      drive_idle();
      r            = $random(seed);
      alu_en       = r[0];
      mult_en      = r[1];
      csr_access   = r[2];
      lsu_en       = r[3];
      lsu_ready_ex = r[4] | r[5];
      wb_ready     = r[6] | r[7];
      branch_in_ex = r[8];
      #2;
      check("bp ex_valid",
            32'((alu_en | mult_en | csr_access | lsu_en) & lsu_ready_ex & wb_ready),
            32'(ex_valid));
      check("bp ex_ready", 32'((lsu_ready_ex & wb_ready) | branch_in_ex), 32'(ex_ready));
    end

    @(negedge clk);
    drive_idle();
    $display("Errors: %0d", errors);
    if (errors == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule
